/* verilog/icache_geom_pkg.sv */
package icache_geom_pkg;

  // fetch address and bus word width
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // address split into tag | index | byte offset
  localparam int TAG_W = 19;
  localparam int IDX_W = 7;
  localparam int OFF_W = 6;

  // 8 KB direct mapped store of 64 byte lines
  localparam int LINES = 128;

  // one refill beat per 32-bit word
  localparam int WORDS_PER_LINE = 16;
  localparam int BEAT_W = 4;

  // four words handed to the aligner
  localparam int WIN_W = 128;

  // top address nibble of the region that bypasses the cache
  localparam logic [3:0] UNCACHED_NIBBLE = 4'hA;

endpackage

/* verilog/icache_inst_pkg.sv */
package icache_inst_pkg;

  // one 32-bit fetch slot
  // read as a whole instruction or built from two halfwords
  typedef union packed {
    logic [31:0] word;
    struct packed {
      logic [15:0] hi;
      logic [15:0] lo;
    } half;
  } fetch_slot_u;

  // fetch sequencing
  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,
    ST_LOOKUP   = 3'd1,
    ST_REFILL   = 3'd2,
    ST_UNCACHED = 3'd3,
    ST_DONE     = 3'd4
  } ctrl_state_e;

endpackage

/* verilog/icache_align.sv */
`timescale 1ns/100ps

module icache_align (
  input  logic [icache_geom_pkg::ADDR_W-1:0] addr_i,
  input  logic [icache_geom_pkg::WIN_W-1:0]  window_i,
  input  logic                               uncached_i,
  input  logic [icache_geom_pkg::DATA_W-1:0] uncached_word_i,
  output logic [icache_geom_pkg::DATA_W-1:0] inst_o
);
  import icache_geom_pkg::*;
  import icache_inst_pkg::*;

  logic [2:0]  hw_sel;
  logic [2:0]  nxt_sel;
  logic [15:0] cur_hw;
  logic [15:0] nxt_hw;
  logic        line_end;
  fetch_slot_u slot;

  // halfword inside the 16 byte window
  assign hw_sel  = addr_i[3:1];
  // wraps into slot 0 which the store fills from the next group
  assign nxt_sel = hw_sel + 3'd1;

  assign cur_hw = window_i[{hw_sel, 4'b0000} +: 16];
  assign nxt_hw = window_i[{nxt_sel, 4'b0000} +: 16];

  // last halfword of the line has nothing after it
  assign line_end = &addr_i[OFF_W-1:1];

  always_comb begin
    slot.half.lo = cur_hw;
    // low bits 11 mark a full 32-bit instruction
    if (cur_hw[1:0] == 2'b11 && !line_end) begin
      slot.half.hi = nxt_hw;
    end else begin
      slot.half.hi = 16'h0000;
    end
  end

  // uncached word goes out untouched
  assign inst_o = uncached_i ? uncached_word_i : slot.word;

endmodule

/* verilog/icache_store.sv */
`timescale 1ns/100ps

module icache_store (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [icache_geom_pkg::ADDR_W-1:0] addr_i,
  input  logic                               wr_en_i,
  input  logic [icache_geom_pkg::BEAT_W-1:0] beat_i,
  input  logic [icache_geom_pkg::DATA_W-1:0] wr_data_i,
  input  logic                               done_line_i,
  output logic                               hit_o,
  output logic [icache_geom_pkg::WIN_W-1:0]  window_o
);
  import icache_geom_pkg::*;

  logic [DATA_W-1:0] data_mem [LINES*WORDS_PER_LINE];
  logic [TAG_W-1:0]  tag_mem [LINES];
  logic [LINES-1:0]  valid_q;
  logic [IDX_W-1:0]  idx;
  logic [TAG_W-1:0]  tag;
  logic [1:0]        grp;
  logic [1:0]        wsel;
  logic              tag_wr;

  assign tag  = addr_i[ADDR_W-1 -: TAG_W];
  assign idx  = addr_i[OFF_W +: IDX_W];
  // 16 byte group and word inside it
  assign grp  = addr_i[OFF_W-1 -: 2];
  assign wsel = addr_i[3:2];

  // done also fires for a single word read so only a line beat counts
  assign tag_wr = wr_en_i && done_line_i;

  assign hit_o = valid_q[idx] && (tag_mem[idx] == tag);

  // slots below the addressed word carry the next group
  // so a full instruction at the group end finds its upper half
  always_comb begin
    logic [1:0] grp_j;
    for (int j = 0; j < 4; j++) begin
      grp_j = (2'(j) < wsel) ? grp + 2'd1 : grp;
      window_o[j*DATA_W +: DATA_W] = data_mem[{idx, grp_j, 2'(j)}];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      data_mem[{idx, beat_i}] <= wr_data_i;
    end
    if (tag_wr) begin
      tag_mem[idx] <= tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_wr) begin
      valid_q[idx] <= 1'b1;
    end
  end

endmodule

/* verilog/icache_refill.sv */
`timescale 1ns/100ps

module icache_refill (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               start_line_i,
  input  logic                               start_word_i,
  input  logic [icache_geom_pkg::ADDR_W-1:0] base_addr_i,
  output logic                               wb_cyc_o,
  output logic                               wb_stb_o,
  output logic [icache_geom_pkg::ADDR_W-1:0] wb_adr_o,
  input  logic                               wb_ack_i,
  input  logic [icache_geom_pkg::DATA_W-1:0] wb_dat_i,
  output logic [icache_geom_pkg::BEAT_W-1:0] beat_o,
  output logic                               wr_en_o,
  output logic [icache_geom_pkg::DATA_W-1:0] wr_data_o,
  output logic                               done_o
);
  import icache_geom_pkg::*;

  logic              busy_q;
  logic              line_q;
  logic [BEAT_W-1:0] beat_q;
  logic [ADDR_W-1:0] adr_q;
  logic              ack_beat;
  logic              last_beat;

  // stb stays up from start to last ack so it waits with cyc
  assign wb_cyc_o = busy_q;
  assign wb_stb_o = busy_q;
  assign wb_adr_o = adr_q;

  assign ack_beat  = busy_q && wb_ack_i;
  assign last_beat = !line_q || (beat_q == BEAT_W'(WORDS_PER_LINE - 1));

  // store write port follows the bus directly
  assign beat_o    = beat_q;
  assign wr_data_o = wb_dat_i;
  assign wr_en_o   = ack_beat && line_q;
  assign done_o    = ack_beat && last_beat;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      beat_q <= '0;
    end else if (start_line_i || start_word_i) begin
      busy_q <= 1'b1;
      beat_q <= '0;
    end else if (done_o) begin
      busy_q <= 1'b0;
    end else if (ack_beat) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  // line reads start at the line base and walk up by words
  always_ff @(posedge clk) begin
    if (start_line_i) begin
      line_q <= 1'b1;
      adr_q  <= {base_addr_i[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    end else if (start_word_i) begin
      line_q <= 1'b0;
      adr_q  <= {base_addr_i[ADDR_W-1:2], 2'b00};
    end else if (ack_beat && !last_beat) begin
      adr_q <= adr_q + ADDR_W'(4);
    end
  end

endmodule

/* verilog/icache_ctrl.sv */
`timescale 1ns/100ps

module icache_ctrl (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               fetch_valid_i,
  input  logic [icache_geom_pkg::ADDR_W-1:0] fetch_addr_i,
  input  logic                               hit_i,
  input  logic                               refill_done_i,
  input  logic [icache_geom_pkg::DATA_W-1:0] uncached_word_i,
  output logic [icache_geom_pkg::ADDR_W-1:0] req_addr_o,
  output logic [icache_geom_pkg::DATA_W-1:0] uncached_word_o,
  output logic                               start_line_o,
  output logic                               start_word_o,
  output logic                               inst_valid_o,
  output logic                               use_uncached_o
);
  import icache_geom_pkg::*;
  import icache_inst_pkg::*;

  ctrl_state_e       state_q;
  ctrl_state_e       state_d;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] unc_word_q;
  logic              in_region;

  // only place the uncached region is tested
  assign in_region = (addr_q[ADDR_W-1 -: 4] == UNCACHED_NIBBLE);

  // refill requests go out in the lookup cycle
  assign start_line_o = (state_q == ST_LOOKUP) && !in_region && !hit_i;
  assign start_word_o = (state_q == ST_LOOKUP) && in_region;

  // hit answers in the lookup cycle itself
  // uncached answers one cycle after its ack
  assign inst_valid_o = ((state_q == ST_LOOKUP) && !in_region && hit_i) ||
                        (state_q == ST_DONE);
  assign use_uncached_o = (state_q == ST_DONE);

  assign req_addr_o      = addr_q;
  assign uncached_word_o = unc_word_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (fetch_valid_i) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (in_region) begin
          state_d = ST_UNCACHED;
        end else if (hit_i) begin
          state_d = ST_IDLE;
        end else begin
          state_d = ST_REFILL;
        end
      end
      // line written on the last ack then look again
      ST_REFILL: begin
        if (refill_done_i) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_UNCACHED: begin
        if (refill_done_i) begin
          state_d = ST_DONE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // request address held from capture until the answer
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && fetch_valid_i) begin
      addr_q <= fetch_addr_i;
    end
    // raw bus word kept for the single answer cycle
    if (state_q == ST_UNCACHED && refill_done_i) begin
      unc_word_q <= uncached_word_i;
    end
  end

endmodule

/* verilog/icache_top.sv */
`timescale 1ns/100ps

module icache_top (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               fetch_valid_i,
  input  logic [icache_geom_pkg::ADDR_W-1:0] fetch_addr_i,
  output logic                               inst_valid_o,
  output logic [icache_geom_pkg::DATA_W-1:0] inst_o,
  output logic                               wb_cyc_o,
  output logic                               wb_stb_o,
  output logic [icache_geom_pkg::ADDR_W-1:0] wb_adr_o,
  input  logic                               wb_ack_i,
  input  logic [icache_geom_pkg::DATA_W-1:0] wb_dat_i
);
  import icache_geom_pkg::*;

  logic              hit;
  logic              refill_done;
  logic              start_line;
  logic              start_word;
  logic              use_uncached;
  logic              wr_en;
  logic [BEAT_W-1:0] beat;
  logic [DATA_W-1:0] wr_data;
  logic [DATA_W-1:0] unc_word;
  logic [ADDR_W-1:0] req_addr;
  logic [WIN_W-1:0]  window;

  // sequencer
  icache_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_addr_i    (fetch_addr_i),
    .hit_i           (hit),
    .refill_done_i   (refill_done),
    .uncached_word_i (wr_data),
    .req_addr_o      (req_addr),
    .uncached_word_o (unc_word),
    .start_line_o    (start_line),
    .start_word_o    (start_word),
    .inst_valid_o    (inst_valid_o),
    .use_uncached_o  (use_uncached)
  );

  // producer on the bus side
  icache_refill u_refill (
    .clk          (clk),
    .rst          (rst),
    .start_line_i (start_line),
    .start_word_i (start_word),
    .base_addr_i  (req_addr),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_adr_o     (wb_adr_o),
    .wb_ack_i     (wb_ack_i),
    .wb_dat_i     (wb_dat_i),
    .beat_o       (beat),
    .wr_en_o      (wr_en),
    .wr_data_o    (wr_data),
    .done_o       (refill_done)
  );

  // line buffer
  icache_store u_store (
    .clk         (clk),
    .rst         (rst),
    .addr_i      (req_addr),
    .wr_en_i     (wr_en),
    .beat_i      (beat),
    .wr_data_i   (wr_data),
    .done_line_i (refill_done),
    .hit_o       (hit),
    .window_o    (window)
  );

  // consumer toward the core
  icache_align u_align (
    .addr_i          (req_addr),
    .window_i        (window),
    .uncached_i      (use_uncached),
    .uncached_word_i (unc_word),
    .inst_o          (inst_o)
  );

endmodule

/* tb/icache_props.sv */
`timescale 1ns/100ps

module icache_props (
  input logic                               clk,
  input logic                               rst,
  input logic                               wb_cyc_i,
  input logic                               wb_stb_i,
  input logic [icache_geom_pkg::ADDR_W-1:0] wb_adr_i,
  input logic                               wb_ack_i,
  input logic                               inst_valid_i,
  input icache_inst_pkg::ctrl_state_e       state_i
);
  import icache_inst_pkg::*;

  int unsigned fail_count = 0;

  // strobe only inside a bus cycle
  stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb_i |-> wb_cyc_i)
    else begin
      fail_count++;
      $error("wb_stb_o high while wb_cyc_o is low");
    end

  // answer is a single cycle pulse
  valid_pulse: assert property (@(posedge clk) disable iff (rst) inst_valid_i |=> !inst_valid_i)
    else begin
      fail_count++;
      $error("inst_valid_o held for more than one cycle");
    end

  // waiting beat keeps strobe and address
  adr_hold: assert property (@(posedge clk) disable iff (rst)
    wb_stb_i && !wb_ack_i |=> wb_stb_i && $stable(wb_adr_i))
    else begin
      fail_count++;
      $error("wb_adr_o or wb_stb_o changed before ack");
    end

  // bus cycle only while the controller waits on a read
  cyc_state: assert property (@(posedge clk) disable iff (rst)
    wb_cyc_i |-> state_i inside {ST_REFILL, ST_UNCACHED})
    else begin
      fail_count++;
      $error("wb_cyc_o high outside refill and uncached states");
    end

endmodule

bind icache_top icache_props u_props (
  .clk          (clk),
  .rst          (rst),
  .wb_cyc_i     (wb_cyc_o),
  .wb_stb_i     (wb_stb_o),
  .wb_adr_i     (wb_adr_o),
  .wb_ack_i     (wb_ack_i),
  .inst_valid_i (inst_valid_o),
  .state_i      (u_ctrl.state_q)
);

/* tb/icache_checker.sv */
`timescale 1ns/100ps

module icache_checker (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               fetch_valid_i,
  input  logic [icache_geom_pkg::ADDR_W-1:0] fetch_addr_i,
  input  logic [icache_geom_pkg::DATA_W-1:0] exp_inst_i,
  input  logic [7:0]                         exp_beats_i,
  input  logic                               inst_valid_i,
  input  logic [icache_geom_pkg::DATA_W-1:0] inst_i,
  input  logic                               wb_cyc_i,
  input  logic                               wb_stb_i,
  input  logic [icache_geom_pkg::ADDR_W-1:0] wb_adr_i,
  input  logic                               wb_ack_i,
  output int unsigned                        errors_o,
  output int unsigned                        beats_o,
  output int unsigned                        pulses_o
);
  import icache_geom_pkg::*;
  import icache_inst_pkg::*;

  logic              pending = 1'b0;
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_inst;
  logic [7:0]        req_beats;
  logic [ADDR_W-1:0] exp_adr;
  fetch_slot_u       exp_slot;
  fetch_slot_u       got_slot;
  int unsigned       req_beat_n;
  int unsigned       cycle = 0;
  int unsigned       cap_cycle;

  initial begin
    errors_o = 0;
    beats_o  = 0;
    pulses_o = 0;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("[ERROR] %0d ns %s expected %0h got %0h", $time, name, exp, got);
    errors_o++;
  endtask

  // answer against the expected word, half by half
  task automatic check_answer();
    exp_slot.word = req_inst;
    got_slot.word = inst_i;
    if (got_slot.half.hi !== exp_slot.half.hi) begin
      report_mismatch("inst_o[31:16]", exp_slot.half.hi, got_slot.half.hi);
    end
    if (got_slot.half.lo !== exp_slot.half.lo) begin
      report_mismatch("inst_o[15:0]", exp_slot.half.lo, got_slot.half.lo);
    end
    if (req_beat_n != req_beats) begin
      report_mismatch("wishbone beats", req_beats, req_beat_n);
    end
    // a hit answers the cycle after capture
    if (req_beats == 8'h00 && cycle != cap_cycle + 1) begin
      $display("hit at %0h answered %0d cycles after capture", req_addr, cycle - cap_cycle);
      errors_o++;
    end
  endtask

  always @(posedge clk) begin
    cycle++;
    if (rst) begin
      pending = 1'b0;
    end else begin
      // bus stays quiet between fetches
      if (!pending && (wb_cyc_i || wb_stb_i)) begin
        $display("bus cycle at %0d ns with no fetch outstanding", $time);
        errors_o++;
      end
      if (wb_stb_i && wb_ack_i) begin
        beats_o++;
        if (pending) begin
          // line beats walk up from the line base
          if (req_beats == 8'h10) begin
            exp_adr = {req_addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}} + 4 * req_beat_n;
          end else begin
            exp_adr = {req_addr[ADDR_W-1:2], 2'b00};
          end
          if (wb_adr_i !== exp_adr) begin
            report_mismatch("wb_adr_o", exp_adr, wb_adr_i);
          end
          req_beat_n++;
        end
      end
      if (inst_valid_i) begin
        pulses_o++;
        if (!pending) begin
          $display("inst_valid_o pulse at %0d ns with no fetch outstanding", $time);
          errors_o++;
        end else begin
          check_answer();
          pending = 1'b0;
        end
      end else if (!pending && fetch_valid_i) begin
        // same edge as the controller capture
        pending    = 1'b1;
        req_addr   = fetch_addr_i;
        req_inst   = exp_inst_i;
        req_beats  = exp_beats_i;
        req_beat_n = 0;
        cap_cycle  = cycle;
      end
    end
  end

endmodule

/* tb/tb_icache.sv */
`timescale 1ns/100ps

module tb_icache;
  import icache_geom_pkg::*;

  localparam int MAX_CASES   = 64;
  localparam int RST_CYCLES  = 10;
  localparam int IDLE_GAP    = 2;
  // 16 beats of at most 4 cycles plus lookup and gap
  localparam int CASE_CYCLES = 16 * 4 + 10;

  logic              clk;
  logic              rst;
  logic              fetch_valid;
  logic [ADDR_W-1:0] fetch_addr;
  logic              inst_valid;
  logic [DATA_W-1:0] inst;
  logic              wb_cyc;
  logic              wb_stb;
  logic [ADDR_W-1:0] wb_adr;
  logic              wb_ack;
  logic [DATA_W-1:0] wb_dat;
  logic [DATA_W-1:0] exp_inst;
  logic [7:0]        exp_beats;
  // address, instruction, beats per case
  logic [31:0]       case_mem [MAX_CASES*3];
  logic [31:0]       lfsr;
  logic              running;
  int                wait_left;
  int unsigned       num_cases;
  int unsigned       run_cycles;
  int unsigned       chk_errors;
  int unsigned       chk_beats;
  int unsigned       chk_pulses;

  icache_top u_icache_top (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid),
    .fetch_addr_i  (fetch_addr),
    .inst_valid_o  (inst_valid),
    .inst_o        (inst),
    .wb_cyc_o      (wb_cyc),
    .wb_stb_o      (wb_stb),
    .wb_adr_o      (wb_adr),
    .wb_ack_i      (wb_ack),
    .wb_dat_i      (wb_dat)
  );

  icache_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid),
    .fetch_addr_i  (fetch_addr),
    .exp_inst_i    (exp_inst),
    .exp_beats_i   (exp_beats),
    .inst_valid_i  (inst_valid),
    .inst_i        (inst),
    .wb_cyc_i      (wb_cyc),
    .wb_stb_i      (wb_stb),
    .wb_adr_i      (wb_adr),
    .wb_ack_i      (wb_ack),
    .errors_o      (chk_errors),
    .beats_o       (chk_beats),
    .pulses_o      (chk_pulses)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // 0..3 wait cycles, one step per bit
  task automatic draw_wait(output int w);
    logic [1:0] bits;
    for (int b = 0; b < 2; b++) begin
      lfsr    = lfsr_step(lfsr);
      bits[b] = lfsr[0];
    end
    w = int'(bits);
  endtask

  // both halfwords carry address bits 17..2
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return {a[17:2], a[17:2]};
  endfunction

  // memory side, ack after a random wait
  always @(negedge clk) begin
    if (rst) begin
      wb_ack    = 1'b0;
      wait_left = -1;
    end else begin
      wb_ack = 1'b0;
      if (wb_stb) begin
        if (wait_left < 0) begin
          draw_wait(wait_left);
        end
        if (wait_left == 0) begin
          wb_ack    = 1'b1;
          wb_dat    = mem_word(wb_adr);
          wait_left = -1;
        end else begin
          wait_left--;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (running) begin
      run_cycles++;
      if (run_cycles > num_cases * CASE_CYCLES) begin
        $display("timeout after %0d cycles, %0d of %0d cases answered",
                 run_cycles, chk_pulses, num_cases);
        $display("TEST RESULT: FAIL");
        $finish;
      end
    end
  end

  // hold the request until the answer pulse
  task automatic fetch_one(input logic [31:0] addr, input logic [31:0] exp_word,
                           input logic [7:0] beats);
    fetch_valid = 1'b1;
    fetch_addr  = addr;
    exp_inst    = exp_word;
    exp_beats   = beats;
    do begin
      @(negedge clk);
    end while (!inst_valid);
    fetch_valid = 1'b0;
    repeat (IDLE_GAP) @(negedge clk);
  endtask

  initial begin
    int unsigned prop_fails;
    int unsigned other_errors;
    int unsigned total_errors;
    rst          = 1'b1;
    fetch_valid  = 1'b0;
    fetch_addr   = '0;
    wb_ack       = 1'b0;
    wb_dat       = '0;
    exp_inst     = '0;
    exp_beats    = '0;
    lfsr         = 32'h6105;
    wait_left    = -1;
    running      = 1'b0;
    run_cycles   = 0;
    other_errors = 0;
    // slots past the last case keep an all-ones beats column
    for (int k = 0; k < MAX_CASES * 3; k++) begin
      case_mem[k] = '1;
    end
    $readmemh("tb/icache_cases.txt", case_mem);
    num_cases = 0;
    while (num_cases < MAX_CASES && case_mem[num_cases*3+2] != '1) begin
      num_cases++;
    end
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // idle after reset, bus must stay quiet
    repeat (5) @(negedge clk);
    running = 1'b1;
    for (int i = 0; i < num_cases; i++) begin
      fetch_one(case_mem[i*3], case_mem[i*3+1], case_mem[i*3+2][7:0]);
    end
    running = 1'b0;
    repeat (4) @(negedge clk);
    if (num_cases == 0) begin
      $display("no cases read from tb/icache_cases.txt");
      other_errors++;
    end
    if (chk_pulses != num_cases) begin
      $display("%0d answer pulses seen for %0d cases", chk_pulses, num_cases);
      other_errors++;
    end
    prop_fails   = u_icache_top.u_props.fail_count;
    total_errors = chk_errors + prop_fails + other_errors;
    $display("cases %0d beats %0d pulses %0d errors %0d (checker %0d assertions %0d other %0d)",
             num_cases, chk_beats, chk_pulses, total_errors, chk_errors, prop_fails,
             other_errors);
    if (total_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tb/icache_cases.txt */
// columns: fetch address, expected instruction, expected wishbone beats
// all hex, beats 10 means a full 16 beat line refill
00001000 00000400 10
00001002 00000400 00
0000100C 04030403 00
0000100E 04040403 00
00001006 00000401 00
0000103E 0000040F 00
0000103C 040F040F 00
0000101E 04080407 00
// same index, other tag, thrashing line 0x40
00003004 00000C01 10
00001000 00000400 10
00003004 00000C01 10
00003008 00000C02 00
00020140 00008050 10
0002014E 80548053 00
// uncached region, raw words and no fill
A0000100 00400040 01
A0000100 00400040 01
A000010E 00430043 01
00000100 00000040 10
00000102 00000040 00

/* build.f */
verilog/icache_geom_pkg.sv
verilog/icache_inst_pkg.sv
verilog/icache_align.sv
verilog/icache_store.sv
verilog/icache_refill.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
tb/icache_props.sv
tb/icache_checker.sv
tb/tb_icache.sv

/* Bender.yml */
package:
  name: icache

sources:
  - verilog/icache_geom_pkg.sv
  - verilog/icache_inst_pkg.sv
  - verilog/icache_align.sv
  - verilog/icache_store.sv
  - verilog/icache_refill.sv
  - verilog/icache_ctrl.sv
  - verilog/icache_top.sv
  - target: simulation
    files:
      - tb/icache_props.sv
      - tb/icache_checker.sv
      - tb/tb_icache.sv
